/* ahb_wbuf_pkg.sv */
/*
 * Shared constants for the AHB-Lite write buffer in front of the SDRAM
 * controller. AHB field widths and codes, buffer line geometry and the
 * idle flush timeout. Referenced by scoped name from every module.
 */

package ahb_wbuf_pkg;

  //////////////////////////////////////////////////////////////////////
  // AHB bus widths
  //////////////////////////////////////////////////////////////////////
  localparam int HADDR_SIZE  = 32;
  localparam int HDATA_SIZE  = 32;
  localparam int HDATA_BYTES = HDATA_SIZE / 8;
  localparam int HSIZE_SIZE  = 3;
  localparam int HTRANS_SIZE = 2;

  // Transfer types
  localparam logic [HTRANS_SIZE-1:0] HTRANS_IDLE   = 2'b00;
  localparam logic [HTRANS_SIZE-1:0] HTRANS_BUSY   = 2'b01;
  localparam logic [HTRANS_SIZE-1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [HTRANS_SIZE-1:0] HTRANS_SEQ    = 2'b11;

  // Transfer sizes, larger ones not supported
  localparam logic [HSIZE_SIZE-1:0] HSIZE_BYTE  = 3'b000;
  localparam logic [HSIZE_SIZE-1:0] HSIZE_HWORD = 3'b001;
  localparam logic [HSIZE_SIZE-1:0] HSIZE_WORD  = 3'b010;

  localparam logic HRESP_OKAY = 1'b0;

  //////////////////////////////////////////////////////////////////////
  // Buffer line geometry
  //////////////////////////////////////////////////////////////////////
  localparam int LINE_BYTES    = 16;
  localparam int LINE_WORDS    = LINE_BYTES / HDATA_BYTES;
  localparam int LINE_ADR_BITS = $clog2(LINE_BYTES);
  localparam int WORD_IDX_BITS = $clog2(LINE_WORDS);
  // Tag is everything above the line offset
  localparam int TAG_SIZE      = HADDR_SIZE - LINE_ADR_BITS;
  localparam int LINE_SIZE     = LINE_BYTES * 8;

  // Idle flush timer
  localparam int                    TIMER_SIZE   = 7;
  localparam logic [TIMER_SIZE-1:0] WBUF_TIMEOUT = 7'd64;

endpackage : ahb_wbuf_pkg

/* ahb_beat_capture.sv */
/*
 * AHB address phase decode. Flags valid writes, splits the address into
 * tag and word index, builds byte lanes and carries them into the data phase.
 */

`timescale 1ns/100ps

module ahb_beat_capture
(
  input  logic                                   HCLK,
  input  logic                                   HRESETn,
  input  logic                                   hsel_i,
  input  logic [ahb_wbuf_pkg::HTRANS_SIZE  -1:0] htrans_i,
  input  logic [ahb_wbuf_pkg::HSIZE_SIZE   -1:0] hsize_i,
  input  logic                                   hwrite_i,
  input  logic [ahb_wbuf_pkg::HADDR_SIZE   -1:0] haddr_i,
  input  logic                                   hready_i,
  output logic                                   addr_write_o,
  output logic                                   beat_write_o,
  output logic [ahb_wbuf_pkg::TAG_SIZE     -1:0] addr_tag_o,
  output logic [ahb_wbuf_pkg::TAG_SIZE     -1:0] beat_tag_o,
  output logic [ahb_wbuf_pkg::WORD_IDX_BITS-1:0] beat_idx_o,
  output logic [ahb_wbuf_pkg::HDATA_BYTES  -1:0] beat_be_o
);

  logic                                 ahb_write;
  logic [ahb_wbuf_pkg::HDATA_BYTES-1:0] addr_be;

  // Write request, IDLE and BUSY carry no transfer
  assign ahb_write = hsel_i & hwrite_i &
                     (htrans_i != ahb_wbuf_pkg::HTRANS_IDLE) &
                     (htrans_i != ahb_wbuf_pkg::HTRANS_BUSY);

  // Only counts when the address phase actually completes
  assign addr_write_o = ahb_write & hready_i;

  assign addr_tag_o = haddr_i[ahb_wbuf_pkg::HADDR_SIZE-1 -: ahb_wbuf_pkg::TAG_SIZE];

  // Byte lanes from size and low address bits
  always_comb
  begin
    case (hsize_i)
      ahb_wbuf_pkg::HSIZE_BYTE:
        addr_be = 4'b0001 << haddr_i[1:0];
      ahb_wbuf_pkg::HSIZE_HWORD:
        addr_be = 4'b0011 << {haddr_i[1], 1'b0};
      // Word, and anything wider clipped to the bus
      default:
        addr_be = 4'b1111;
    endcase
  end

  //////////////////////////////////////////////////////////////////////
  // Address phase to data phase
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      beat_write_o <= 1'b0;
    else if (hready_i)
      beat_write_o <= ahb_write;
  end

  // Beat payload
  always_ff @(posedge HCLK)
  begin
    if (hready_i)
    begin
      beat_tag_o <= addr_tag_o;
      beat_idx_o <= haddr_i[ahb_wbuf_pkg::LINE_ADR_BITS-1 -: ahb_wbuf_pkg::WORD_IDX_BITS];
      beat_be_o  <= addr_be;
    end
  end

endmodule : ahb_beat_capture

/* wbuf_pingpong_store.sv */
/*
 * Two line buffers used ping-pong. The active half merges AHB write data
 * bytewise, the other half holds the line being flushed to SDRAM.
 */

`timescale 1ns/100ps

module wbuf_pingpong_store
(
  input  logic                                   HCLK,
  input  logic                                   HRESETn,
  input  logic                                   pingpong_i,
  input  logic                                   toggle_i,
  input  logic                                   we_i,
  input  logic [ahb_wbuf_pkg::TAG_SIZE     -1:0] beat_tag_i,
  input  logic [ahb_wbuf_pkg::WORD_IDX_BITS-1:0] beat_idx_i,
  input  logic [ahb_wbuf_pkg::HDATA_BYTES  -1:0] beat_be_i,
  input  logic [ahb_wbuf_pkg::HDATA_SIZE   -1:0] hwdata_i,
  input  logic                                   accept_i,
  output logic [ahb_wbuf_pkg::TAG_SIZE     -1:0] act_tag_o,
  output logic                                   act_dirty_o,
  output logic                                   oth_dirty_o,
  output logic [ahb_wbuf_pkg::TAG_SIZE     -1:0] flush_tag_o,
  output logic [ahb_wbuf_pkg::LINE_SIZE    -1:0] flush_line_o,
  output logic [ahb_wbuf_pkg::LINE_BYTES   -1:0] flush_be_o
);

  // Per-half storage
  logic [ahb_wbuf_pkg::LINE_SIZE -1:0] line_q  [2];
  logic [ahb_wbuf_pkg::LINE_BYTES-1:0] be_q    [2];
  logic [ahb_wbuf_pkg::TAG_SIZE  -1:0] tag_q   [2];
  logic                                dirty_q [2];

  //////////////////////////////////////////////////////////////////////
  // Line data
  //////////////////////////////////////////////////////////////////////

  // Merge enabled lanes only, untouched bytes keep older writes
  always_ff @(posedge HCLK)
  begin
    if (we_i)
    begin
      for (int b = 0; b < ahb_wbuf_pkg::HDATA_BYTES; b++)
      begin
        if (beat_be_i[b])
          line_q[pingpong_i][beat_idx_i*ahb_wbuf_pkg::HDATA_SIZE + b*8 +: 8] <=
            hwdata_i[b*8 +: 8];
      end
    end
  end

  // Tag follows the latest write into the active half
  always_ff @(posedge HCLK)
  begin
    if (we_i)
      tag_q[pingpong_i] <= beat_tag_i;
  end

  //////////////////////////////////////////////////////////////////////
  // Byte enable masks
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      be_q[0] <= '0;
      be_q[1] <= '0;
    end
    else
    begin
      // Half about to become active starts empty
      if (toggle_i)
        be_q[~pingpong_i] <= '0;

      if (we_i)
        be_q[pingpong_i][beat_idx_i*ahb_wbuf_pkg::HDATA_BYTES +: ahb_wbuf_pkg::HDATA_BYTES] <=
          be_q[pingpong_i][beat_idx_i*ahb_wbuf_pkg::HDATA_BYTES +: ahb_wbuf_pkg::HDATA_BYTES] |
          beat_be_i;
    end
  end

  // Dirty set by writes, cleared once the SDRAM side took the line
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      dirty_q[0] <= 1'b0;
      dirty_q[1] <= 1'b0;
    end
    else
    begin
      if (we_i)
        dirty_q[pingpong_i] <= 1'b1;
      if (accept_i)
        dirty_q[~pingpong_i] <= 1'b0;
    end
  end

  // Active half status
  assign act_tag_o   = tag_q[pingpong_i];
  assign act_dirty_o = dirty_q[pingpong_i];
  assign oth_dirty_o = dirty_q[~pingpong_i];

  // Flushing half contents
  assign flush_tag_o  = tag_q[~pingpong_i];
  assign flush_line_o = line_q[~pingpong_i];
  assign flush_be_o   = be_q[~pingpong_i];

endmodule : wbuf_pingpong_store

/* wbuf_flush_ctrl.sv */
/*
 * Flush decision for the write buffer. Detects buffer misses, runs the idle
 * timer, toggles the ping-pong select and inserts AHB wait states while
 * both halves are dirty.
 */

`timescale 1ns/100ps

module wbuf_flush_ctrl
(
  input  logic                               HCLK,
  input  logic                               HRESETn,
  input  logic                               addr_write_i,
  input  logic                               beat_write_i,
  input  logic [ahb_wbuf_pkg::TAG_SIZE -1:0] addr_tag_i,
  input  logic [ahb_wbuf_pkg::TAG_SIZE -1:0] beat_tag_i,
  input  logic [ahb_wbuf_pkg::TAG_SIZE -1:0] act_tag_i,
  input  logic                               act_dirty_i,
  input  logic                               oth_dirty_i,
  input  logic                               req_busy_i,
  input  logic                               accept_i,
  output logic                               pingpong_o,
  output logic                               toggle_o,
  output logic                               we_o,
  output logic                               hreadyout_o,
  output logic                               hresp_o
);

  typedef enum logic {ST_IDLE = 1'b0, ST_WAIT = 1'b1} state_t;

  state_t                                state_q, state_d;
  logic                                  hreadyout_d;
  logic                                  miss;
  logic                                  other_free;
  logic                                  timer_expired;
  logic [ahb_wbuf_pkg::TIMER_SIZE-1:0]   timer_q;

  assign hresp_o = ahb_wbuf_pkg::HRESP_OKAY;

  // Data phase write, held off during wait states
  assign we_o = beat_write_i & hreadyout_o;

  // Miss against the stored line or the write still landing
  assign miss = addr_write_i &
                ((act_dirty_i & (addr_tag_i != act_tag_i)) |
                 (we_o        & (addr_tag_i != beat_tag_i)));

  // Other half may take over, or frees up this cycle
  assign other_free = accept_i | (~oth_dirty_i & ~req_busy_i);

  //////////////////////////////////////////////////////////////////////
  // Idle timer
  //////////////////////////////////////////////////////////////////////
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
      timer_q <= ahb_wbuf_pkg::WBUF_TIMEOUT;
    else if (!act_dirty_i || beat_write_i)
      timer_q <= ahb_wbuf_pkg::WBUF_TIMEOUT;
    else if (|timer_q)
      timer_q <= timer_q - 1'b1;
  end

  // Sticks at zero until the half is flushed
  assign timer_expired = act_dirty_i & ~|timer_q;

  //////////////////////////////////////////////////////////////////////
  // Flush FSM
  //////////////////////////////////////////////////////////////////////
  always_comb
  begin
    state_d     = state_q;
    hreadyout_d = hreadyout_o;
    toggle_o    = 1'b0;

    case (state_q)
      ST_IDLE:
      begin
        if (miss)
        begin
          if (other_free)
            toggle_o = 1'b1;
          else
          begin
            // Stall the missing write until the older line is gone
            state_d     = ST_WAIT;
            hreadyout_d = 1'b0;
          end
        end
        // Timer flush just waits for a free half, no stall
        else if (timer_expired && other_free)
          toggle_o = 1'b1;
      end

      ST_WAIT:
      begin
        if (accept_i)
        begin
          toggle_o    = 1'b1;
          state_d     = ST_IDLE;
          hreadyout_d = 1'b1;
        end
      end

      default: state_d = ST_IDLE;
    endcase
  end

  // State, ready and active half select
  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      state_q     <= ST_IDLE;
      hreadyout_o <= 1'b1;
      pingpong_o  <= 1'b0;
    end
    else
    begin
      state_q     <= state_d;
      hreadyout_o <= hreadyout_d;
      pingpong_o  <= pingpong_o ^ toggle_o;
    end
  end

endmodule : wbuf_flush_ctrl

/* sdram_wr_req.sv */
/*
 * SDRAM side of the write buffer. Copies the flushed line after a swap and
 * holds wrreq with address, enables and data until wrrdy is seen.
 */

`timescale 1ns/100ps

module sdram_wr_req
(
  input  logic                                HCLK,
  input  logic                                HRESETn,
  input  logic                                toggle_i,
  input  logic [ahb_wbuf_pkg::TAG_SIZE  -1:0] flush_tag_i,
  input  logic [ahb_wbuf_pkg::LINE_SIZE -1:0] flush_line_i,
  input  logic [ahb_wbuf_pkg::LINE_BYTES-1:0] flush_be_i,
  input  logic                                wrrdy_i,
  output logic                                wrreq_o,
  output logic [ahb_wbuf_pkg::HADDR_SIZE-1:0] wradr_o,
  output logic [ahb_wbuf_pkg::LINE_BYTES-1:0] wrbe_o,
  output logic [ahb_wbuf_pkg::LINE_SIZE -1:0] wrd_o,
  output logic                                req_busy_o,
  output logic                                accept_o
);

  // Load the line, then raise the request
  logic load_q;
  logic issue_q;

  always_ff @(posedge HCLK or negedge HRESETn)
  begin
    if (!HRESETn)
    begin
      load_q  <= 1'b0;
      issue_q <= 1'b0;
      wrreq_o <= 1'b0;
    end
    else
    begin
      load_q  <= toggle_i;
      issue_q <= load_q;
      // Held as a level until the scheduler takes it
      if (issue_q)
        wrreq_o <= 1'b1;
      else if (wrrdy_i)
        wrreq_o <= 1'b0;
    end
  end

  // Request payload, stable while wrreq is up
  always_ff @(posedge HCLK)
  begin
    if (load_q)
    begin
      wradr_o <= {flush_tag_i, {ahb_wbuf_pkg::LINE_ADR_BITS{1'b0}}};
      wrbe_o  <= flush_be_i;
      wrd_o   <= flush_line_i;
    end
  end

  assign accept_o   = wrreq_o & wrrdy_i;
  assign req_busy_o = load_q | issue_q | wrreq_o;

endmodule : sdram_wr_req

/* ahb_sdram_wbuf.sv */
/*
 * AHB-Lite write port with a ping-pong line buffer in front of the SDRAM
 * scheduler. Reads and idle transfers complete with zero wait states.
 */

`timescale 1ns/100ps

module ahb_sdram_wbuf
(
  input  logic                                 HCLK,
  input  logic                                 HRESETn,
  // AHB-Lite slave
  input  logic                                 hsel_i,
  input  logic [ahb_wbuf_pkg::HTRANS_SIZE-1:0] htrans_i,
  input  logic [ahb_wbuf_pkg::HSIZE_SIZE -1:0] hsize_i,
  input  logic                                 hwrite_i,
  input  logic [ahb_wbuf_pkg::HADDR_SIZE -1:0] haddr_i,
  input  logic [ahb_wbuf_pkg::HDATA_SIZE -1:0] hwdata_i,
  input  logic                                 hready_i,
  output logic                                 hreadyout_o,
  output logic                                 hresp_o,
  // SDRAM write request
  output logic                                 wrreq_o,
  input  logic                                 wrrdy_i,
  output logic [ahb_wbuf_pkg::HADDR_SIZE -1:0] wradr_o,
  output logic [ahb_wbuf_pkg::LINE_BYTES -1:0] wrbe_o,
  output logic [ahb_wbuf_pkg::LINE_SIZE  -1:0] wrd_o
);

  logic                                   addr_write, beat_write;
  logic [ahb_wbuf_pkg::TAG_SIZE     -1:0] addr_tag, beat_tag, act_tag, flush_tag;
  logic [ahb_wbuf_pkg::WORD_IDX_BITS-1:0] beat_idx;
  logic [ahb_wbuf_pkg::HDATA_BYTES  -1:0] beat_be;
  logic                                   pingpong, toggle, we;
  logic                                   act_dirty, oth_dirty, req_busy, accept;
  logic [ahb_wbuf_pkg::LINE_SIZE    -1:0] flush_line;
  logic [ahb_wbuf_pkg::LINE_BYTES   -1:0] flush_be;

  ahb_beat_capture u_capture (
    .HCLK, .HRESETn, .hsel_i, .htrans_i, .hsize_i, .hwrite_i, .haddr_i, .hready_i,
    .addr_write_o (addr_write), .beat_write_o (beat_write), .addr_tag_o (addr_tag),
    .beat_tag_o   (beat_tag),   .beat_idx_o   (beat_idx),   .beat_be_o  (beat_be));

  wbuf_pingpong_store u_store (
    .HCLK, .HRESETn, .pingpong_i (pingpong), .toggle_i (toggle), .we_i (we),
    .beat_tag_i  (beat_tag),  .beat_idx_i  (beat_idx),  .beat_be_i (beat_be),
    .hwdata_i, .accept_i (accept), .act_tag_o (act_tag), .act_dirty_o (act_dirty),
    .oth_dirty_o (oth_dirty), .flush_tag_o (flush_tag), .flush_line_o (flush_line),
    .flush_be_o  (flush_be));

  wbuf_flush_ctrl u_flush_ctrl (
    .HCLK, .HRESETn, .addr_write_i (addr_write), .beat_write_i (beat_write),
    .addr_tag_i  (addr_tag),  .beat_tag_i (beat_tag), .act_tag_i (act_tag),
    .act_dirty_i (act_dirty), .oth_dirty_i (oth_dirty), .req_busy_i (req_busy),
    .accept_i (accept), .pingpong_o (pingpong), .toggle_o (toggle), .we_o (we),
    .hreadyout_o, .hresp_o);

  sdram_wr_req u_wr_req (
    .HCLK, .HRESETn, .toggle_i (toggle), .flush_tag_i (flush_tag),
    .flush_line_i (flush_line), .flush_be_i (flush_be), .wrrdy_i,
    .wrreq_o, .wradr_o, .wrbe_o, .wrd_o, .req_busy_o (req_busy), .accept_o (accept));

endmodule : ahb_sdram_wbuf

/* tb_ahb_sdram_wbuf_properties.sv */
/*
 * Protocol checks on the SDRAM write request and the AHB response.
 * Bound into the write buffer top level, counts its own failures.
 */

`timescale 1ns/100ps

module tb_ahb_sdram_wbuf_properties
(
  input logic                                 HCLK,
  input logic                                 HRESETn,
  input logic                                 wrreq_i,
  input logic                                 wrrdy_i,
  input logic [ahb_wbuf_pkg::HADDR_SIZE -1:0] wradr_i,
  input logic [ahb_wbuf_pkg::LINE_BYTES -1:0] wrbe_i,
  input logic [ahb_wbuf_pkg::LINE_SIZE  -1:0] wrd_i,
  input logic                                 hresp_i
);

  int fail_cnt = 0;

  // Request and payload frozen until the scheduler takes them
  req_stable: assert property (@(posedge HCLK) disable iff (!HRESETn)
    wrreq_i && !wrrdy_i |=> wrreq_i && $stable(wradr_i) && $stable(wrbe_i) && $stable(wrd_i))
  else
  begin
    $error("write request dropped or changed before wrrdy");
    fail_cnt++;
  end

  // Line aligned
  adr_aligned: assert property (@(posedge HCLK) disable iff (!HRESETn)
    wrreq_i |-> wradr_i[ahb_wbuf_pkg::LINE_ADR_BITS-1:0] == '0)
  else
  begin
    $error("write request address not line aligned");
    fail_cnt++;
  end

  // First cycle out of reset
  req_after_reset: assert property (@(posedge HCLK) $rose(HRESETn) |-> !wrreq_i)
  else
  begin
    $error("write request high right after reset");
    fail_cnt++;
  end

  resp_okay: assert property (@(posedge HCLK) hresp_i == ahb_wbuf_pkg::HRESP_OKAY)
  else
  begin
    $error("hresp not OKAY");
    fail_cnt++;
  end

endmodule : tb_ahb_sdram_wbuf_properties

bind ahb_sdram_wbuf tb_ahb_sdram_wbuf_properties u_props
(
  .HCLK    (HCLK),
  .HRESETn (HRESETn),
  .wrreq_i (wrreq_o),
  .wrrdy_i (wrrdy_i),
  .wradr_i (wradr_o),
  .wrbe_i  (wrbe_o),
  .wrd_i   (wrd_o),
  .hresp_i (hresp_o)
);

/* tb_ahb_sdram_wbuf.sv */
/*
 * Testbench for the AHB write buffer. Drives writes, reads and idle
 * transfers, keeps a byte model of every line and checks each request
 * taken by the SDRAM side against it.
 */

`timescale 1ns/100ps

module tb_ahb_sdram_wbuf;

  // Tests plus timer drains take well under 1000 cycles
  localparam int MAX_CYCLES = 4000;

  logic                                 HCLK;
  logic                                 HRESETn;
  logic                                 hsel_i;
  logic [ahb_wbuf_pkg::HTRANS_SIZE-1:0] htrans_i;
  logic [ahb_wbuf_pkg::HSIZE_SIZE -1:0] hsize_i;
  logic                                 hwrite_i;
  logic [ahb_wbuf_pkg::HADDR_SIZE -1:0] haddr_i;
  logic [ahb_wbuf_pkg::HDATA_SIZE -1:0] hwdata_i;
  logic                                 hready_i;
  logic                                 hreadyout_o;
  logic                                 hresp_o;
  logic                                 wrreq_o;
  logic                                 wrrdy_i;
  logic [ahb_wbuf_pkg::HADDR_SIZE -1:0] wradr_o;
  logic [ahb_wbuf_pkg::LINE_BYTES -1:0] wrbe_o;
  logic [ahb_wbuf_pkg::LINE_SIZE  -1:0] wrd_o;

  // Open line model and lines waiting for the SDRAM side
  logic [ahb_wbuf_pkg::LINE_SIZE -1:0]  m_data;
  logic [ahb_wbuf_pkg::LINE_BYTES-1:0]  m_mask;
  logic [ahb_wbuf_pkg::TAG_SIZE  -1:0]  m_tag;
  logic                                 m_open;
  logic [ahb_wbuf_pkg::HADDR_SIZE-1:0]  exp_adr  [$];
  logic [ahb_wbuf_pkg::LINE_BYTES-1:0]  exp_be   [$];
  logic [ahb_wbuf_pkg::LINE_SIZE -1:0]  exp_data [$];

  logic [ahb_wbuf_pkg::HDATA_SIZE-1:0]  pend_data;
  integer seed = 32'hd5d3;
  int     rdy_hold, rdy_high;
  int     cycles, req_count, stall_cycles;
  int     errors, checks, err_mark, tests_run, tests_failed;
  int     r0, s0, n;

  ahb_sdram_wbuf ahb_sdram_wbuf_i (.*);

  initial HCLK = 1'b0;
  always #50 HCLK = ~HCLK;

  // Single slave, ready loops back
  always @(negedge HCLK)
    hready_i <= hreadyout_o;

  always @(posedge HCLK)
  begin
    cycles++;
    if (cycles >= MAX_CYCLES)
    begin
      $display("timeout: run still busy after %0d cycles", cycles);
      $display("Test failed");
      $finish;
    end
  end

  function automatic int total_errors();
    return errors + ahb_sdram_wbuf_i.u_props.fail_cnt;
  endfunction

  ////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////
  task automatic expect_eq(input logic [ahb_wbuf_pkg::LINE_SIZE-1:0] got,
                           input logic [ahb_wbuf_pkg::LINE_SIZE-1:0] exp, input string what);
    checks++;
    assert (got === exp)
    else
    begin
      $display("error: %0t: %0s is %h, expected %h", $time, what, got, exp);
      errors++;
    end
  endtask

  task automatic expect_true(input logic cond, input string what);
    checks++;
    assert (cond)
    else
    begin
      $display("error: %0t: %0s", $time, what);
      errors++;
    end
  endtask

  // Request taken at the coming rising edge, compare with oldest line
  task automatic check_request();
    logic [ahb_wbuf_pkg::LINE_SIZE-1:0] keep;
    req_count++;
    if (exp_adr.size() == 0)
    begin
      $display("error: %0t: write request to %h with no line pending", $time, wradr_o);
      errors++;
      return;
    end
    // Bytes never written are don't care
    for (int i = 0; i < ahb_wbuf_pkg::LINE_BYTES; i++)
      keep[i*8 +: 8] = {8{exp_be[0][i]}};
    expect_eq(wradr_o, exp_adr[0], "wradr");
    expect_eq(wrbe_o, exp_be[0], "wrbe");
    expect_eq(wrd_o & keep, exp_data[0] & keep, "wrd");
    exp_adr.delete(0);
    exp_be.delete(0);
    exp_data.delete(0);
  endtask

  // Scheduler side, random ready unless a test holds it
  always @(negedge HCLK)
  begin : scheduler
    logic rdy;
    if (rdy_hold > 0)
    begin
      rdy = 1'b0;
      rdy_hold--;
    end
    else if (rdy_high != 0)
      rdy = 1'b1;
    else
      rdy = ($random(seed) % 2) != 0;
    wrrdy_i <= rdy;
    if (HRESETn && wrreq_o && rdy)
      check_request();
  end

  ////////////////////////////////////////////////////////////////////
  // Line model
  ////////////////////////////////////////////////////////////////////
  task automatic close_line();
    if (m_open)
    begin
      exp_adr.push_back({m_tag, {ahb_wbuf_pkg::LINE_ADR_BITS{1'b0}}});
      exp_be.push_back(m_mask);
      exp_data.push_back(m_data);
    end
    m_open = 1'b0;
    m_mask = '0;
  endtask

  task automatic model_write(input logic [31:0] addr, input logic [2:0] size,
                             input logic [31:0] data);
    logic lane;
    int   idx;
    idx = addr[3:2];
    // New line while one is open means a miss
    if (m_open && addr[31:4] != m_tag)
      close_line();
    for (int b = 0; b < ahb_wbuf_pkg::HDATA_BYTES; b++)
    begin
      lane = (size == ahb_wbuf_pkg::HSIZE_WORD) ||
             (size == ahb_wbuf_pkg::HSIZE_HWORD && (b / 2) == addr[1]) ||
             (size == ahb_wbuf_pkg::HSIZE_BYTE && b == addr[1:0]);
      if (lane)
      begin
        m_data[(idx*4 + b)*8 +: 8] = data[b*8 +: 8];
        m_mask[idx*4 + b]          = 1'b1;
      end
    end
    m_tag  = addr[31:4];
    m_open = 1'b1;
  endtask

  ////////////////////////////////////////////////////////////////////
  // AHB master
  ////////////////////////////////////////////////////////////////////
  // One address phase, plus data phase of the previous transfer
  task automatic bus_cycle(input logic sel, input logic [1:0] trans, input logic write,
                           input logic [31:0] addr, input logic [2:0] size,
                           input logic [31:0] wdata);
    logic is_write;
    hsel_i   = sel;
    htrans_i = trans;
    hwrite_i = write;
    haddr_i  = addr;
    hsize_i  = size;
    hwdata_i = pend_data;
    @(posedge HCLK);
    while (!hready_i)
    begin
      stall_cycles++;
      @(posedge HCLK);
    end
    is_write = sel && write && (trans == ahb_wbuf_pkg::HTRANS_NONSEQ ||
                                trans == ahb_wbuf_pkg::HTRANS_SEQ);
    if (is_write)
      model_write(addr, size, wdata);
    pend_data = wdata;
    @(negedge HCLK);
  endtask

  task automatic idle_cycle();
    bus_cycle(1'b0, ahb_wbuf_pkg::HTRANS_IDLE, 1'b0, '0, ahb_wbuf_pkg::HSIZE_WORD, '0);
  endtask

  task automatic write_word(input logic [31:0] addr, input logic [31:0] data);
    bus_cycle(1'b1, ahb_wbuf_pkg::HTRANS_NONSEQ, 1'b1, addr, ahb_wbuf_pkg::HSIZE_WORD, data);
  endtask

  // Narrow data replicated on every lane
  task automatic write_half(input logic [31:0] addr, input logic [15:0] data);
    bus_cycle(1'b1, ahb_wbuf_pkg::HTRANS_NONSEQ, 1'b1, addr, ahb_wbuf_pkg::HSIZE_HWORD,
              {2{data}});
  endtask

  task automatic write_byte(input logic [31:0] addr, input logic [7:0] data);
    bus_cycle(1'b1, ahb_wbuf_pkg::HTRANS_NONSEQ, 1'b1, addr, ahb_wbuf_pkg::HSIZE_BYTE,
              {4{data}});
  endtask

  // Let the idle timer push out the open line and wait until all are taken
  task automatic drain();
    idle_cycle();
    close_line();
    while (exp_adr.size() != 0 || wrreq_o)
      idle_cycle();
  endtask

  task automatic finish_test(input string name);
    int errs;
    errs = total_errors() - err_mark;
    tests_run++;
    if (errs != 0)
      tests_failed++;
    $display("%0s finished, %0d errors", name, errs);
    err_mark = total_errors();
  endtask

  ////////////////////////////////////////////////////////////////////
  // Tests
  ////////////////////////////////////////////////////////////////////
  initial
  begin
    HRESETn   = 1'b0;
    hsel_i    = 1'b0;
    htrans_i  = ahb_wbuf_pkg::HTRANS_IDLE;
    hsize_i   = ahb_wbuf_pkg::HSIZE_WORD;
    hwrite_i  = 1'b0;
    haddr_i   = '0;
    hwdata_i  = '0;
    hready_i  = 1'b1;
    wrrdy_i   = 1'b0;
    pend_data = '0;
    m_data    = '0;
    m_mask    = '0;
    m_tag     = '0;
    m_open    = 1'b0;
    repeat (10) @(negedge HCLK);
    HRESETn = 1'b1;

    expect_true(hreadyout_o && !wrreq_o, "ready low or request high after reset");
    idle_cycle();
    finish_test("reset");

    // Full line then a miss gives exactly one request
    r0 = req_count;
    for (int i = 0; i < 4; i++)
      write_word(32'h0000_1000 + 4*i, 32'ha0a0_0000 + i);
    write_word(32'h0000_2004, 32'hb0b0_0004);
    idle_cycle();
    while (req_count == r0)
      idle_cycle();
    repeat (5) idle_cycle();
    expect_true(req_count - r0 == 1, "line miss did not give exactly one request");
    drain();
    finish_test("merge_and_miss");

    // Byte lanes and a byte overwritten
    write_byte(32'h0000_3000, 8'h11);
    write_byte(32'h0000_3005, 8'h22);
    write_half(32'h0000_300a, 16'hbeef);
    write_byte(32'h0000_3005, 8'h77);
    write_half(32'h0000_300c, 16'h3344);
    drain();
    finish_test("partial_writes");

    // Older line held back, second miss must stall
    r0       = req_count;
    s0       = stall_cycles;
    rdy_hold = 40;
    write_word(32'h0000_4000, 32'h4444_0000);
    write_word(32'h0000_4008, 32'h4444_0008);
    write_word(32'h0000_5000, 32'h5555_0000);
    write_word(32'h0000_5004, 32'h5555_0004);
    write_word(32'h0000_6000, 32'h6666_0000);
    idle_cycle();
    expect_true(stall_cycles > s0, "second miss under back-pressure did not stall");
    expect_true(req_count > r0, "stall ended before the older line was taken");
    drain();
    expect_true(req_count - r0 == 3, "back-pressure lines lost or duplicated");
    finish_test("back_pressure");

    // Idle timer flush, scheduler always ready
    rdy_high = 1;
    write_word(32'h0000_700c, 32'h7777_000c);
    idle_cycle();
    close_line();
    n = 0;
    while (!wrreq_o && n < ahb_wbuf_pkg::WBUF_TIMEOUT + 10)
    begin
      idle_cycle();
      n++;
    end
    expect_true(wrreq_o && n <= ahb_wbuf_pkg::WBUF_TIMEOUT + 3,
                "idle line not flushed within the timeout");
    drain();
    rdy_high = 0;
    finish_test("timeout_flush");

    // Reads, BUSY, IDLE and unselected writes leave the line alone
    r0 = req_count;
    s0 = stall_cycles;
    write_word(32'h0000_8004, 32'h8888_0004);
    bus_cycle(1'b1, ahb_wbuf_pkg::HTRANS_NONSEQ, 1'b0, 32'h0000_9000,
              ahb_wbuf_pkg::HSIZE_WORD, 32'hdead_beef);
    bus_cycle(1'b1, ahb_wbuf_pkg::HTRANS_SEQ, 1'b0, 32'h0000_9004,
              ahb_wbuf_pkg::HSIZE_WORD, 32'hdead_beef);
    bus_cycle(1'b1, ahb_wbuf_pkg::HTRANS_BUSY, 1'b1, 32'h0000_9008,
              ahb_wbuf_pkg::HSIZE_WORD, 32'hdead_beef);
    bus_cycle(1'b1, ahb_wbuf_pkg::HTRANS_IDLE, 1'b1, 32'h0000_a000,
              ahb_wbuf_pkg::HSIZE_WORD, 32'hdead_beef);
    bus_cycle(1'b0, ahb_wbuf_pkg::HTRANS_NONSEQ, 1'b1, 32'h0000_b000,
              ahb_wbuf_pkg::HSIZE_WORD, 32'hdead_beef);
    bus_cycle(1'b1, ahb_wbuf_pkg::HTRANS_NONSEQ, 1'b0, 32'h0000_8004,
              ahb_wbuf_pkg::HSIZE_WORD, 32'hdead_beef);
    write_word(32'h0000_8008, 32'h8888_0008);
    repeat (5) idle_cycle();
    expect_true(req_count == r0 && stall_cycles == s0,
                "read or idle transfer caused a request or a wait state");
    drain();
    finish_test("reads_and_idle");

    $display("tests %0d, failed %0d, checks %0d, errors %0d",
             tests_run, tests_failed, checks, total_errors());
    if (tests_failed == 0 && total_errors() == 0)
      $display("Test completed successfully");
    else
      $display("Test failed");
    $finish;
  end

endmodule : tb_ahb_sdram_wbuf

/* project.f */
ahb_wbuf_pkg.sv
ahb_beat_capture.sv
wbuf_pingpong_store.sv
wbuf_flush_ctrl.sv
sdram_wr_req.sv
ahb_sdram_wbuf.sv
tb_ahb_sdram_wbuf_properties.sv
tb_ahb_sdram_wbuf.sv
